//--- Makefile
# Verilator flow for the sgd compute path, run from the project root

VERILATOR ?= verilator
TOP       ?= sgd_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  := Finished with no errors
FAIL_MSG  := Finished with errors

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
+incdir+source
source/sgd_data_pkg.sv
source/sgd_reg_pkg.sv
source/sgd_ifaces.sv
source/sgd_param_regs.sv
source/sgd_dispatch.sv
source/sgd_engine.sv
source/sgd_send_back.sv
source/sgd_top.sv
test/sgd_tb.sv

//--- source/sgd_config.svh
// shared sizes, register offsets and reset values, included by packages and RTL
`ifndef SGD_CONFIG_SVH
`define SGD_CONFIG_SVH

// engine row and datapath widths
`define SGD_ENGINE_NUM      4
`define SGD_FEAT_W          16
`define SGD_ACC_W           40
`define SGD_CNT_W           16
`define SGD_SHIFT_W         5

// apb bus sizes
`define SGD_APB_AW          8
`define SGD_APB_DW          32

// register offsets, byte addressed
`define SGD_ADDR_CTRL       8'h00
`define SGD_ADDR_MINI_BATCH 8'h04
`define SGD_ADDR_STEP_SHIFT 8'h08
`define SGD_ADDR_NUM_SMP    8'h0C
`define SGD_ADDR_STATUS     8'h10

// parameter values after reset
`define SGD_MINI_BATCH_RST  16'd8
`define SGD_STEP_SHIFT_RST  5'd0
`define SGD_NUM_SMP_RST     16'd0

`endif

//--- source/sgd_data_pkg.sv
// datapath types shared by dispatcher, engines and send-back
`default_nettype none

`include "sgd_config.svh"

package sgd_data_pkg;

    // one feature, or the shared label b
    typedef logic signed [`SGD_FEAT_W-1:0] feat_t;

    // running sum and result word
    typedef logic signed [`SGD_ACC_W-1:0] acc_t;

    // beat, sample and batch counters
    typedef logic [`SGD_CNT_W-1:0] cnt_t;

    // engine fsm
    typedef enum logic {
        ENG_ACCUM,
        ENG_HOLD
    } engine_state_e;

endpackage

`default_nettype wire

//--- source/sgd_dispatch.sv
// run control and sample fan-out from the input stream to every engine lane
`default_nettype none

`include "sgd_config.svh"

module sgd_dispatch import sgd_data_pkg::*; (
    input  logic                            hbm_clk,
    input  logic                            hbm_rstn,
    input  logic                            start,
    input  cnt_t                            num_samples,
    input  feat_t [`SGD_ENGINE_NUM-1:0]     sample_feat,
    input  feat_t                           sample_label,
    input  logic                            sample_last,
    input  logic                            sample_valid,
    output logic                            sample_ready,
    output logic                            busy,
    output cnt_t                            sample_count,
    sample_if.dispatcher                    eng [`SGD_ENGINE_NUM]
);

    logic [`SGD_ENGINE_NUM-1:0] eng_ready;
    logic                       all_ready;
    logic                       count_hit;
    logic                       end_beat;
    logic                       fire;

    // any engine holding a result stalls the whole row
    assign all_ready    = &eng_ready;
    assign sample_ready = busy & all_ready;
    assign fire         = sample_valid & sample_ready;

    // num_samples of 0 leaves the run to the last flag
    assign count_hit = (num_samples != '0) && (sample_count + cnt_t'(1) == num_samples);
    assign end_beat  = sample_last | count_hit;

    // lane i gets feature i, label and last go to all
    for (genvar i = 0; i < `SGD_ENGINE_NUM; i++) begin : g_lane
        assign eng_ready[i] = eng[i].ready;
        assign eng[i].feat  = sample_feat[i];
        assign eng[i].label = sample_label;
        assign eng[i].last  = end_beat;
        assign eng[i].valid = sample_valid & busy & all_ready;
    end

    // run state and taken-sample count
    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            busy         <= 1'b0;
            sample_count <= '0;
        end else if (start) begin
            busy         <= 1'b1;
            sample_count <= '0;
        end else if (fire) begin
            sample_count <= sample_count + cnt_t'(1);
            // drops the cycle after the closing beat
            if (end_beat)
                busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/sgd_engine.sv
// one gradient engine, feature times label summed per mini-batch then shifted
`default_nettype none

`include "sgd_config.svh"

module sgd_engine import sgd_data_pkg::*; (
    input  logic                    hbm_clk,
    input  logic                    hbm_rstn,
    input  cnt_t                    mini_batch,
    input  logic [`SGD_SHIFT_W-1:0] step_shift,
    sample_if.engine                smp,
    result_if.engine                res
);

    engine_state_e state_q;
    acc_t          acc_q;
    acc_t          prod;
    acc_t          sum_next;
    cnt_t          beat_cnt_q;
    cnt_t          batch_q;
    acc_t          result_q;
    cnt_t          batch_out_q;
    logic          beat;
    logic          close;

    // take beats only while accumulating
    assign smp.ready = (state_q == ENG_ACCUM);
    assign beat      = smp.valid & smp.ready;

    // sign extend before multiply
    assign prod     = acc_t'(smp.feat) * acc_t'(smp.label);
    assign sum_next = acc_q + prod;

    // batch full, or run ends early
    assign close = smp.last | (beat_cnt_q + cnt_t'(1) == mini_batch);

    assign res.valid  = (state_q == ENG_HOLD);
    assign res.result = result_q;
    assign res.batch  = batch_out_q;

    ////////////////////////////////////////////////////////////
    // fsm and accumulator
    ////////////////////////////////////////////////////////////

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            state_q    <= ENG_ACCUM;
            acc_q      <= '0;
            beat_cnt_q <= '0;
            batch_q    <= '0;
        end else begin
            case (state_q)
                ENG_ACCUM: begin
                    if (beat && close) begin
                        acc_q      <= '0;
                        beat_cnt_q <= '0;
                        // numbering starts over for the next run
                        batch_q    <= smp.last ? '0 : batch_q + cnt_t'(1);
                        state_q    <= ENG_HOLD;
                    end else if (beat) begin
                        acc_q      <= sum_next;
                        beat_cnt_q <= beat_cnt_q + cnt_t'(1);
                    end
                end
                ENG_HOLD: begin
                    // wait for send-back to take it
                    if (res.ready)
                        state_q <= ENG_ACCUM;
                end
                default: state_q <= ENG_ACCUM;
            endcase
        end
    end

    // result word, arithmetic shift keeps the sign
    always_ff @(posedge hbm_clk) begin
        if (state_q == ENG_ACCUM && beat && close) begin
            result_q    <= sum_next >>> step_shift;
            batch_out_q <= batch_q;
        end
    end

endmodule

`default_nettype wire

//--- source/sgd_ifaces.sv
// sample and result handshake bundles between dispatcher, engines and send-back
`default_nettype none

// one sample lane, dispatcher to one engine
interface sample_if import sgd_data_pkg::*; ();
    feat_t feat;
    feat_t label;
    logic  last;
    logic  valid;
    logic  ready;

    modport dispatcher (output feat, label, last, valid, input ready);
    modport engine     (input feat, label, last, valid, output ready);
endinterface

// one result lane, engine to send-back
interface result_if import sgd_data_pkg::*; ();
    acc_t result;
    cnt_t batch;
    logic valid;
    logic ready;

    modport engine (output result, batch, valid, input ready);
    modport drain  (input result, batch, valid, output ready);
endinterface

`default_nettype wire

//--- source/sgd_param_regs.sv
// apb slave holding the training parameters, start pulse and run status
`default_nettype none

`include "sgd_config.svh"

module sgd_param_regs import sgd_reg_pkg::*, sgd_data_pkg::*; (
    input  logic                   hbm_clk,
    input  logic                   hbm_rstn,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`SGD_APB_AW-1:0] paddr,
    input  logic [`SGD_APB_DW-1:0] pwdata,
    output logic [`SGD_APB_DW-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    output sgd_params_t            params,
    output logic                   start,
    input  cnt_t                   sample_count,
    input  logic                   busy
);

    logic wr_acc;
    logic mapped;

    // zero wait state slave
    assign pready = 1'b1;

    // write in access phase
    assign wr_acc = psel & penable & pwrite;

    assign mapped = paddr inside {REG_CTRL, REG_MINI_BATCH, REG_STEP_SHIFT,
                                  REG_NUM_SAMPLES, REG_STATUS};

    // status is read only
    assign pslverr = wr_acc & (~mapped | (paddr == REG_STATUS));

    ////////////////////////////////////////////////////////////
    // parameter registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            params.mini_batch  <= `SGD_MINI_BATCH_RST;
            params.step_shift  <= `SGD_STEP_SHIFT_RST;
            params.num_samples <= `SGD_NUM_SMP_RST;
            start              <= 1'b0;
        end else begin
            // one cycle only
            start <= 1'b0;
            if (wr_acc) begin
                case (paddr)
                    REG_CTRL: begin
                        // ignored while a run is going
                        if (ctrl_op_e'(pwdata) == OP_START && !busy && !start)
                            start <= 1'b1;
                    end
                    REG_MINI_BATCH:  params.mini_batch  <= pwdata[`SGD_CNT_W-1:0];
                    REG_STEP_SHIFT:  params.step_shift  <= pwdata[`SGD_SHIFT_W-1:0];
                    REG_NUM_SAMPLES: params.num_samples <= pwdata[`SGD_CNT_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        prdata = '0;
        case (paddr)
            REG_MINI_BATCH:  prdata[`SGD_CNT_W-1:0]   = params.mini_batch;
            REG_STEP_SHIFT:  prdata[`SGD_SHIFT_W-1:0] = params.step_shift;
            REG_NUM_SAMPLES: prdata[`SGD_CNT_W-1:0]   = params.num_samples;
            // count on top, busy at bit 0
            REG_STATUS:      prdata = {sample_count, 15'd0, busy};
            default:         prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/sgd_reg_pkg.sv
// register map types for the apb parameter block, imported by regs and testbench
`default_nettype none

`include "sgd_config.svh"

package sgd_reg_pkg;

    // register offsets seen on paddr
    typedef enum logic [`SGD_APB_AW-1:0] {
        REG_CTRL        = `SGD_ADDR_CTRL,
        REG_MINI_BATCH  = `SGD_ADDR_MINI_BATCH,
        REG_STEP_SHIFT  = `SGD_ADDR_STEP_SHIFT,
        REG_NUM_SAMPLES = `SGD_ADDR_NUM_SMP,
        REG_STATUS      = `SGD_ADDR_STATUS
    } reg_addr_e;

    // commands written to REG_CTRL
    typedef enum logic [`SGD_APB_DW-1:0] {
        OP_NONE  = 32'd0,
        OP_START = 32'd1
    } ctrl_op_e;

    // training parameters as held by the register block
    typedef struct packed {
        logic [`SGD_CNT_W-1:0]   mini_batch;
        logic [`SGD_SHIFT_W-1:0] step_shift;
        logic [`SGD_CNT_W-1:0]   num_samples;
    } sgd_params_t;

endpackage

`default_nettype wire

//--- source/sgd_send_back.sv
// round-robin drain of engine results onto the registered result port
`default_nettype none

`include "sgd_config.svh"

module sgd_send_back import sgd_data_pkg::*; (
    input  logic                                hbm_clk,
    input  logic                                hbm_rstn,
    result_if.drain                             eng [`SGD_ENGINE_NUM],
    output acc_t                                x_data_out,
    output logic [$clog2(`SGD_ENGINE_NUM)-1:0]  x_data_out_engine,
    output cnt_t                                x_data_out_batch,
    output logic                                x_data_out_valid,
    input  logic                                x_data_out_almost_full
);

    localparam int IDX_W = $clog2(`SGD_ENGINE_NUM);

    logic [IDX_W-1:0]           ptr_q;
    logic [`SGD_ENGINE_NUM-1:0] eng_valid;
    acc_t                       eng_result [`SGD_ENGINE_NUM];
    cnt_t                       eng_batch  [`SGD_ENGINE_NUM];
    logic                       take;

    // results stay in the engines while the sink is almost full
    assign take = eng_valid[ptr_q] & ~x_data_out_almost_full;

    // flatten lanes and give ready only to the pointed engine
    for (genvar i = 0; i < `SGD_ENGINE_NUM; i++) begin : g_lane
        assign eng_valid[i]  = eng[i].valid;
        assign eng_result[i] = eng[i].result;
        assign eng_batch[i]  = eng[i].batch;
        assign eng[i].ready  = take & (ptr_q == IDX_W'(i));
    end

    // pointer waits on the current engine, then wraps
    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            ptr_q            <= '0;
            x_data_out_valid <= 1'b0;
        end else begin
            x_data_out_valid <= take;
            if (take)
                ptr_q <= (ptr_q == IDX_W'(`SGD_ENGINE_NUM - 1)) ? '0 : ptr_q + IDX_W'(1);
        end
    end

    // output word with its tags
    always_ff @(posedge hbm_clk) begin
        if (take) begin
            x_data_out        <= eng_result[ptr_q];
            x_data_out_engine <= ptr_q;
            x_data_out_batch  <= eng_batch[ptr_q];
        end
    end

endmodule

`default_nettype wire

//--- source/sgd_top.sv
// rtl top of the sgd compute path, apb registers, dispatch, engines, send-back
`default_nettype none

`include "sgd_config.svh"

module sgd_top import sgd_reg_pkg::*, sgd_data_pkg::*; (
    input  logic                               hbm_clk,
    input  logic                               hbm_rstn,
    // apb register port
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [`SGD_APB_AW-1:0]             paddr,
    input  logic [`SGD_APB_DW-1:0]             pwdata,
    output logic [`SGD_APB_DW-1:0]             prdata,
    output logic                               pready,
    output logic                               pslverr,
    // sample stream in
    input  feat_t [`SGD_ENGINE_NUM-1:0]        sample_feat,
    input  feat_t                              sample_label,
    input  logic                               sample_last,
    input  logic                               sample_valid,
    output logic                               sample_ready,
    // result stream out
    output acc_t                               x_data_out,
    output logic [$clog2(`SGD_ENGINE_NUM)-1:0] x_data_out_engine,
    output cnt_t                               x_data_out_batch,
    output logic                               x_data_out_valid,
    input  logic                               x_data_out_almost_full
);

    sgd_params_t params;
    logic        start;
    logic        busy;
    cnt_t        sample_count;

    // one lane pair per engine
    sample_if smp_bus [`SGD_ENGINE_NUM] ();
    result_if res_bus [`SGD_ENGINE_NUM] ();

    sgd_param_regs u_param_regs (
        .hbm_clk      (hbm_clk),
        .hbm_rstn     (hbm_rstn),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .params       (params),
        .start        (start),
        .sample_count (sample_count),
        .busy         (busy)
    );

    sgd_dispatch u_dispatch (
        .hbm_clk      (hbm_clk),
        .hbm_rstn     (hbm_rstn),
        .start        (start),
        .num_samples  (params.num_samples),
        .sample_feat  (sample_feat),
        .sample_label (sample_label),
        .sample_last  (sample_last),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .busy         (busy),
        .sample_count (sample_count),
        .eng          (smp_bus)
    );

    ////////////////////////////////////////////////////////////
    // engine row
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `SGD_ENGINE_NUM; i++) begin : g_engine
        sgd_engine u_engine (
            .hbm_clk    (hbm_clk),
            .hbm_rstn   (hbm_rstn),
            .mini_batch (params.mini_batch),
            .step_shift (params.step_shift),
            .smp        (smp_bus[i]),
            .res        (res_bus[i])
        );
    end

    sgd_send_back u_send_back (
        .hbm_clk                (hbm_clk),
        .hbm_rstn               (hbm_rstn),
        .eng                    (res_bus),
        .x_data_out             (x_data_out),
        .x_data_out_engine      (x_data_out_engine),
        .x_data_out_batch       (x_data_out_batch),
        .x_data_out_valid       (x_data_out_valid),
        .x_data_out_almost_full (x_data_out_almost_full)
    );

endmodule

`default_nettype wire

//--- test/sgd_stimulus.txt
# W addr data pslverr | R addr expected | S feat0 feat1 feat2 feat3 label last | X engine batch value
# addr and register words in hex, all other columns decimal
# out of reset
R 04 00000008
R 10 00000000
# run 1, mini_batch 2, no shift, 4 samples
W 04 00000002 0
W 08 00000000 0
W 0C 00000004 0
R 04 00000002
R 08 00000000
R 0C 00000004
W 10 00000001 1
W 00 00000001 0
S 1 2 3 4 5 0
S -1 6 0 7 3 0
X 0 0 2
X 1 0 28
X 2 0 15
X 3 0 41
S 10 -20 30 -40 -2 0
S 100 200 300 400 1 0
X 0 1 80
X 1 1 240
X 2 1 240
X 3 1 480
R 10 00040000
# run 2, mini_batch 3, shift 2, 5 samples, short last batch
W 04 00000003 0
W 08 00000002 0
W 0C 00000005 0
W 00 00000001 0
S 3 -5 7 -9 4 0
S -6 2 5 1 3 0
S 1 1 1 1 -7 0
X 0 0 -4
X 1 0 -6
X 2 0 9
X 3 0 -10
S 100 -100 50 -50 10 0
S 2 3 -4 -5 6 0
X 0 1 253
X 1 1 -246
X 2 1 119
X 3 1 -133
R 10 00050000

//--- test/sgd_tb.sv
// self-checking testbench for sgd_top, run from the project root, reads test/sgd_stimulus.txt
`default_nettype none

`include "sgd_config.svh"

module sgd_tb import sgd_reg_pkg::*, sgd_data_pkg::*; ();

    localparam int    CLK_PERIOD = 4;
    localparam int    ARGS       = `SGD_ENGINE_NUM + 2;
    localparam string STIM_FILE  = "test/sgd_stimulus.txt";

    typedef logic [`SGD_APB_AW-1:0]             apb_addr_t;
    typedef logic [`SGD_APB_DW-1:0]             apb_data_t;
    typedef logic [$clog2(`SGD_ENGINE_NUM)-1:0] eng_idx_t;

    logic                        hbm_clk;
    logic                        hbm_rstn;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    apb_addr_t                   paddr;
    apb_data_t                   pwdata;
    apb_data_t                   prdata;
    logic                        pready;
    logic                        pslverr;
    feat_t [`SGD_ENGINE_NUM-1:0] sample_feat;
    feat_t                       sample_label;
    logic                        sample_last;
    logic                        sample_valid;
    logic                        sample_ready;
    acc_t                        x_data_out;
    eng_idx_t                    x_data_out_engine;
    cnt_t                        x_data_out_batch;
    logic                        x_data_out_valid;
    logic                        x_data_out_almost_full;

    // commands in file order, ARGS slots each
    byte      cmd_kind [$];
    longint   cmd_arg  [$];
    // expected result stream
    acc_t     exp_value  [$];
    eng_idx_t exp_engine [$];
    cnt_t     exp_batch  [$];

    integer seed = 35;
    int     errors;
    int     checks;
    int     results_seen;
    int     exp_total;
    int     wd_cycles;
    logic   load_ok;

    sgd_top sgd_top_i (
        .hbm_clk                (hbm_clk),
        .hbm_rstn               (hbm_rstn),
        .psel                   (psel),
        .penable                (penable),
        .pwrite                 (pwrite),
        .paddr                  (paddr),
        .pwdata                 (pwdata),
        .prdata                 (prdata),
        .pready                 (pready),
        .pslverr                (pslverr),
        .sample_feat            (sample_feat),
        .sample_label           (sample_label),
        .sample_last            (sample_last),
        .sample_valid           (sample_valid),
        .sample_ready           (sample_ready),
        .x_data_out             (x_data_out),
        .x_data_out_engine      (x_data_out_engine),
        .x_data_out_batch       (x_data_out_batch),
        .x_data_out_valid       (x_data_out_valid),
        .x_data_out_almost_full (x_data_out_almost_full)
    );

    always #(CLK_PERIOD / 2) hbm_clk = ~hbm_clk;

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_result(input acc_t exp, input acc_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %0t: x_data_out expected %0d got %0d", $time, exp, act);
        end
    endtask

    task automatic check_tag(input eng_idx_t exp_eng, input eng_idx_t act_eng,
                             input cnt_t exp_bat, input cnt_t act_bat);
        checks++;
        if (act_eng !== exp_eng || act_bat !== exp_bat)
            errors++;
        if (act_eng !== exp_eng)
            $display("[ERROR] %0t: x_data_out_engine expected %0d got %0d",
                     $time, exp_eng, act_eng);
        if (act_bat !== exp_bat)
            $display("[ERROR] %0t: x_data_out_batch expected %0d got %0d",
                     $time, exp_bat, act_bat);
    endtask

    task automatic check_reg(input string name, input apb_data_t exp, input apb_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus file
    ////////////////////////////////////////////////////////////

    task automatic load_stimulus();
        int     fd;
        int     c;
        int     code;
        int     want;
        int     lines;
        byte    kind;
        longint v [ARGS];
        lines = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open stimulus file %s", STIM_FILE);
            return;
        end
        while ($fscanf(fd, " %c", kind) == 1) begin
            foreach (v[k])
                v[k] = 0;
            code = 0;
            want = 0;
            if (kind == "#") begin
                // comment runs to end of line
                c = $fgetc(fd);
                while (c != 10 && c != -1)
                    c = $fgetc(fd);
            end else if (kind == "W") begin
                want = 3;
                code = $fscanf(fd, "%h %h %d", v[0], v[1], v[2]);
            end else if (kind == "R") begin
                want = 2;
                code = $fscanf(fd, "%h %h", v[0], v[1]);
            end else if (kind == "S") begin
                want = 6;
                code = $fscanf(fd, "%d %d %d %d %d %d", v[0], v[1], v[2], v[3], v[4], v[5]);
            end else if (kind == "X") begin
                want = 3;
                code = $fscanf(fd, "%d %d %d", v[0], v[1], v[2]);
            end else begin
                errors++;
                $display("unknown line kind '%c' in stimulus file", kind);
            end
            if (code != want) begin
                errors++;
                $display("stimulus line %0d has %0d fields, %0d needed", lines + 1, code, want);
            end else if (kind == "X") begin
                exp_engine.push_back(eng_idx_t'(v[0]));
                exp_batch.push_back(cnt_t'(v[1]));
                exp_value.push_back(acc_t'(v[2]));
                lines++;
            end else if (want != 0) begin
                cmd_kind.push_back(kind);
                foreach (v[k])
                    cmd_arg.push_back(v[k]);
                lines++;
            end
        end
        $fclose(fd);
        exp_total = exp_value.size();
        load_ok   = (errors == 0) && (lines != 0);
        if (lines == 0) begin
            errors++;
            $display("stimulus file holds no commands");
        end
        wd_cycles = lines * 200;
    endtask

    ////////////////////////////////////////////////////////////
    // bus drivers
    ////////////////////////////////////////////////////////////

    // setup then access, pslverr looked at mid access
    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
        @(posedge hbm_clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge hbm_clk);
        #1;
        penable = 1'b1;
        @(negedge hbm_clk);
        check_flag("pready", 1'b1, pready);
        check_flag($sformatf("pslverr[%h]", addr), exp_err, pslverr);
        @(posedge hbm_clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, input apb_data_t exp);
        reg_addr_e ra;
        ra = reg_addr_e'(addr);
        @(posedge hbm_clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge hbm_clk);
        #1;
        penable = 1'b1;
        @(negedge hbm_clk);
        check_reg($sformatf("prdata[%s]", ra.name()), exp, prdata);
        @(posedge hbm_clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // hold the beat until the row takes it
    task automatic send_beat(input int base);
        @(posedge hbm_clk);
        #1;
        for (int k = 0; k < `SGD_ENGINE_NUM; k++)
            sample_feat[k] = feat_t'(cmd_arg[base + k]);
        sample_label = feat_t'(cmd_arg[base + `SGD_ENGINE_NUM]);
        sample_last  = (cmd_arg[base + `SGD_ENGINE_NUM + 1] != 0);
        sample_valid = 1'b1;
        // ready comes from registered state only
        @(negedge hbm_clk);
        while (!sample_ready)
            @(negedge hbm_clk);
        @(posedge hbm_clk);
        #1;
        sample_valid = 1'b0;
        sample_last  = 1'b0;
    endtask

    task automatic run_commands();
        int base;
        for (int c = 0; c < cmd_kind.size(); c++) begin
            base = c * ARGS;
            case (cmd_kind[c])
                "W": apb_write(apb_addr_t'(cmd_arg[base]), apb_data_t'(cmd_arg[base + 1]),
                               cmd_arg[base + 2] != 0);
                "R": apb_read(apb_addr_t'(cmd_arg[base]), apb_data_t'(cmd_arg[base + 1]));
                "S": send_beat(base);
                default: ;
            endcase
        end
    endtask

    ////////////////////////////////////////////////////////////
    // sink side
    ////////////////////////////////////////////////////////////

    // random back-pressure once out of reset
    always @(posedge hbm_clk) begin
        #1;
        x_data_out_almost_full = hbm_rstn && (($random(seed) & 32'sd1) != 0);
    end

    always @(negedge hbm_clk) begin : result_monitor
        acc_t     want_value;
        eng_idx_t want_engine;
        cnt_t     want_batch;
        if (hbm_rstn && x_data_out_valid) begin
            results_seen++;
            if (exp_value.size() == 0) begin
                errors++;
                $display("result %0d from engine %0d arrived with none left to expect",
                         x_data_out, x_data_out_engine);
            end else begin
                want_value  = exp_value.pop_front();
                want_engine = exp_engine.pop_front();
                want_batch  = exp_batch.pop_front();
                check_result(want_value, x_data_out);
                check_tag(want_engine, x_data_out_engine, want_batch, x_data_out_batch);
            end
        end
    end

    // limit scales with the stimulus length
    initial begin : watchdog
        wait (wd_cycles != 0);
        #(wd_cycles * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, %0d of %0d results seen",
                 wd_cycles, results_seen, exp_total);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        hbm_clk                = 1'b0;
        hbm_rstn               = 1'b0;
        psel                   = 1'b0;
        penable                = 1'b0;
        pwrite                 = 1'b0;
        paddr                  = '0;
        pwdata                 = '0;
        sample_feat            = '0;
        sample_label           = '0;
        sample_last            = 1'b0;
        sample_valid           = 1'b0;
        x_data_out_almost_full = 1'b0;
        errors                 = 0;
        checks                 = 0;
        results_seen           = 0;
        load_ok                = 1'b0;
        load_stimulus();
        repeat (3) @(posedge hbm_clk);
        #1;
        hbm_rstn = 1'b1;
        // idle outputs after reset
        @(negedge hbm_clk);
        check_flag("pready", 1'b1, pready);
        check_flag("pslverr", 1'b0, pslverr);
        check_flag("sample_ready", 1'b0, sample_ready);
        check_flag("x_data_out_valid", 1'b0, x_data_out_valid);
        if (load_ok) begin
            run_commands();
            while (exp_value.size() != 0)
                @(negedge hbm_clk);
            // quiet window to catch extra words
            repeat (4 * `SGD_ENGINE_NUM) @(posedge hbm_clk);
        end
        $display("checks %0d, errors %0d, results %0d of %0d",
                 checks, errors, results_seen, exp_total);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire
